/* include/vliw_cfg.svh */
`ifndef VLIW_CFG_SVH
`define VLIW_CFG_SVH

// Architectural register count
`define VLIW_NUM_GPR 32

// Data word width
`define VLIW_WORD_W 32

// Slot word for a killed slot, opcode 111000
`define VLIW_NOP_SLOT 32'hE000_0000

`endif

/* source/isa_pkg.sv */
`default_nettype none
`include "vliw_cfg.svh"

package isa_pkg;

    typedef logic [`VLIW_WORD_W-1:0] word_t;
    typedef logic [$clog2(`VLIW_NUM_GPR)-1:0] reg_idx_t;

    // Six-bit major opcodes in bits 31:26 of a slot
    typedef enum logic [5:0] {
        OP_ADDI  = 6'b000000,
        OP_SUBI  = 6'b000001,
        OP_ADD   = 6'b000010,
        OP_SUB   = 6'b000011,
        OP_SRAWI = 6'b000100,
        OP_SLAWI = 6'b000101,
        OP_LI    = 6'b010010,
        OP_LIW   = 6'b010011
    } opcode_t;

    // Operation selected in the ALU
    typedef enum logic [3:0] {
        E_NOP    = 4'b0000,
        E_ADD    = 4'b0001,
        E_SUB    = 4'b0010,
        E_RSHIFT = 4'b0011,
        E_LSHIFT = 4'b0100,
        E_PASS   = 4'b0101
    } exec_type_t;

    // Immediate form, slot bits 25:0
    typedef struct packed {
        reg_idx_t    rt;
        reg_idx_t    ra;
        logic [15:0] si;
    } dform_t;

    // Register form, slot bits 25:0
    typedef struct packed {
        reg_idx_t    rt;
        reg_idx_t    ra;
        reg_idx_t    rb;
        logic [10:0] unused;
    } xform_t;

endpackage

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // One decoded lane headed for the ALU
    typedef struct packed {
        isa_pkg::exec_type_t e_type;
        isa_pkg::word_t      srca;
        isa_pkg::word_t      srcb;
        isa_pkg::reg_idx_t   rt;
        logic                rt_flag;
    } lane_op_t;

    // Lane result, valid means rt gets written
    typedef struct packed {
        logic                valid;
        isa_pkg::reg_idx_t   rt;
        isa_pkg::word_t      value;
    } lane_result_t;

    // Register file read addresses for one lane
    typedef struct packed {
        isa_pkg::reg_idx_t   ra;
        isa_pkg::reg_idx_t   rb;
    } gpr_rd_t;

endpackage

`default_nettype wire

/* source/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vliw_cfg.svh"

module gpr_file (
    input  logic                   clk,
    input  logic                   rstn,
    input  pipe_pkg::gpr_rd_t      upper_rd,
    input  pipe_pkg::gpr_rd_t      lower_rd,
    output isa_pkg::word_t         upper_a,
    output isa_pkg::word_t         upper_b,
    output isa_pkg::word_t         lower_a,
    output isa_pkg::word_t         lower_b,
    input  pipe_pkg::lane_result_t upper_wr,
    input  pipe_pkg::lane_result_t lower_wr
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [`VLIW_NUM_GPR];

    // Write-through read, lower lane has priority like the write order
    function automatic word_t read_port(input reg_idx_t idx, input word_t stored,
                                        input lane_result_t up, input lane_result_t lo);
        if (lo.valid && lo.rt == idx)
            return lo.value;
        if (up.valid && up.rt == idx)
            return up.value;
        return stored;
    endfunction

    assign upper_a = read_port(upper_rd.ra, regs[upper_rd.ra], upper_wr, lower_wr);
    assign upper_b = read_port(upper_rd.rb, regs[upper_rd.rb], upper_wr, lower_wr);
    assign lower_a = read_port(lower_rd.ra, regs[lower_rd.ra], upper_wr, lower_wr);
    assign lower_b = read_port(lower_rd.rb, regs[lower_rd.rb], upper_wr, lower_wr);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `VLIW_NUM_GPR; i++)
                regs[i] <= '0;
        end else begin
            if (upper_wr.valid)
                regs[upper_wr.rt] <= upper_wr.value;
            // Lower write last so it wins on the same index
            if (lower_wr.valid)
                regs[lower_wr.rt] <= lower_wr.value;
        end
    end

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  pipe_pkg::gpr_rd_t      upper_rd,
    input  pipe_pkg::gpr_rd_t      lower_rd,
    input  isa_pkg::opcode_t       upper_kind,
    input  isa_pkg::opcode_t       lower_kind,
    input  pipe_pkg::lane_op_t     dec_upper,
    input  pipe_pkg::lane_op_t     dec_lower,
    input  pipe_pkg::lane_result_t alu_upper,
    input  pipe_pkg::lane_result_t alu_lower,
    output logic                   busy
);
    import isa_pkg::*;

    logic kill_lower;
    logic upper_hit;
    logic lower_hit;

    function automatic logic reads_ra(input opcode_t kind);
        return kind inside {OP_ADDI, OP_SUBI, OP_ADD, OP_SUB, OP_SRAWI, OP_SLAWI};
    endfunction

    function automatic logic reads_rb(input opcode_t kind);
        return kind inside {OP_ADD, OP_SUB};
    endfunction

    // Writeback stage is covered by the register file bypass
    function automatic logic in_flight(input reg_idx_t idx);
        return (dec_upper.rt_flag && dec_upper.rt == idx)
            || (dec_lower.rt_flag && dec_lower.rt == idx)
            || (alu_upper.valid && alu_upper.rt == idx)
            || (alu_lower.valid && alu_lower.rt == idx);
    endfunction

    assign kill_lower = (upper_kind == OP_LIW);

    always_comb begin
        upper_hit = (reads_ra(upper_kind) && in_flight(upper_rd.ra))
                 || (reads_rb(upper_kind) && in_flight(upper_rd.rb));
        // Lower word of a liw is data, not an instruction
        lower_hit = !kill_lower
                 && ((reads_ra(lower_kind) && in_flight(lower_rd.ra))
                 ||  (reads_rb(lower_kind) && in_flight(lower_rd.rb)));
    end

    assign busy = upper_hit || lower_hit;

endmodule

`default_nettype wire

/* source/bundle_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vliw_cfg.svh"

module bundle_decode (
    input  logic               clk,
    input  logic               rstn,
    input  logic [63:0]        bundle,
    input  logic               bundle_valid,
    input  logic               busy,
    output pipe_pkg::gpr_rd_t  upper_rd,
    output pipe_pkg::gpr_rd_t  lower_rd,
    input  isa_pkg::word_t     upper_a,
    input  isa_pkg::word_t     upper_b,
    input  isa_pkg::word_t     lower_a,
    input  isa_pkg::word_t     lower_b,
    output pipe_pkg::lane_op_t upper_op,
    output pipe_pkg::lane_op_t lower_op
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t  upper_slot;
    word_t  lower_slot;
    dform_t upper_d;
    dform_t lower_d;
    xform_t upper_x;
    xform_t lower_x;
    logic   accept;

    // Decode one slot word; wide is the liw immediate
    function automatic lane_op_t decode_lane(input word_t slot, input word_t a,
                                             input word_t b, input word_t wide,
                                             input logic liw_ok);
        dform_t   d;
        lane_op_t op;
        d          = dform_t'(slot[25:0]);
        op.e_type  = E_NOP;
        op.srca    = a;
        op.srcb    = {{16{d.si[15]}}, d.si};
        op.rt      = d.rt;
        op.rt_flag = 1'b0;
        case (opcode_t'(slot[31:26]))
            OP_ADDI: begin
                op.e_type  = E_ADD;
                op.rt_flag = 1'b1;
            end
            OP_SUBI: begin
                op.e_type  = E_SUB;
                op.rt_flag = 1'b1;
            end
            OP_ADD: begin
                op.e_type  = E_ADD;
                op.srcb    = b;
                op.rt_flag = 1'b1;
            end
            OP_SUB: begin
                op.e_type  = E_SUB;
                op.srcb    = b;
                op.rt_flag = 1'b1;
            end
            OP_SRAWI: begin
                op.e_type  = E_RSHIFT;
                op.rt_flag = 1'b1;
            end
            OP_SLAWI: begin
                op.e_type  = E_LSHIFT;
                op.rt_flag = 1'b1;
            end
            OP_LI: begin
                op.e_type  = E_PASS;
                op.rt_flag = 1'b1;
            end
            OP_LIW: begin
                // Only meaningful in the upper slot
                if (liw_ok) begin
                    op.e_type  = E_PASS;
                    op.srcb    = wide;
                    op.rt_flag = 1'b1;
                end
            end
            default: ;
        endcase
        return op;
    endfunction

    assign upper_slot = bundle[63:32];
    // liw swallows the lower word
    assign lower_slot = (opcode_t'(bundle[63:58]) == OP_LIW) ? `VLIW_NOP_SLOT : bundle[31:0];

    assign upper_d = dform_t'(upper_slot[25:0]);
    assign upper_x = xform_t'(upper_slot[25:0]);
    assign lower_d = dform_t'(lower_slot[25:0]);
    assign lower_x = xform_t'(lower_slot[25:0]);

    assign upper_rd.ra = upper_d.ra;
    assign upper_rd.rb = upper_x.rb;
    assign lower_rd.ra = lower_d.ra;
    assign lower_rd.rb = lower_x.rb;

    assign accept = bundle_valid && !busy;

    always_ff @(posedge clk) begin
        if (!rstn || !accept) begin
            // Bubble
            upper_op.e_type  <= E_NOP;
            upper_op.rt_flag <= 1'b0;
            lower_op.e_type  <= E_NOP;
            lower_op.rt_flag <= 1'b0;
        end else begin
            upper_op <= decode_lane(upper_slot, upper_a, upper_b, bundle[31:0], 1'b1);
            lower_op <= decode_lane(lower_slot, lower_a, lower_b, lower_slot, 1'b0);
        end
    end

endmodule

`default_nettype wire

/* source/dual_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_alu (
    input  logic                   clk,
    input  logic                   rstn,
    input  pipe_pkg::lane_op_t     upper_op,
    input  pipe_pkg::lane_op_t     lower_op,
    output pipe_pkg::lane_result_t upper_res,
    output pipe_pkg::lane_result_t lower_res
);
    import isa_pkg::*;
    import pipe_pkg::*;

    function automatic word_t execute(input lane_op_t op);
        word_t res;
        case (op.e_type)
            E_ADD:    res = op.srca + op.srcb;
            E_SUB:    res = op.srca - op.srcb;
            E_RSHIFT: res = word_t'($signed(op.srca) >>> op.srcb[4:0]);
            E_LSHIFT: res = op.srca << op.srcb[4:0];
            E_PASS:   res = op.srcb;
            default:  res = '0;
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            upper_res.valid <= 1'b0;
            lower_res.valid <= 1'b0;
        end else begin
            upper_res.valid <= upper_op.rt_flag;
            lower_res.valid <= lower_op.rt_flag;
        end
        upper_res.rt    <= upper_op.rt;
        upper_res.value <= execute(upper_op);
        lower_res.rt    <= lower_op.rt;
        lower_res.value <= execute(lower_op);
    end

endmodule

`default_nettype wire

/* source/writeback_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  logic                   clk,
    input  logic                   rstn,
    input  pipe_pkg::lane_result_t upper_res,
    input  pipe_pkg::lane_result_t lower_res,
    output pipe_pkg::lane_result_t upper_wr,
    output pipe_pkg::lane_result_t lower_wr,
    output pipe_pkg::lane_result_t wb_upper,
    output pipe_pkg::lane_result_t wb_lower
);
    import pipe_pkg::*;

    lane_result_t upper_q;
    lane_result_t lower_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            upper_q.valid <= 1'b0;
            lower_q.valid <= 1'b0;
        end else begin
            upper_q.valid <= upper_res.valid;
            lower_q.valid <= lower_res.valid;
        end
        upper_q.rt    <= upper_res.rt;
        lower_q.rt    <= lower_res.rt;
        // Idle lanes show zero
        upper_q.value <= upper_res.valid ? upper_res.value : '0;
        lower_q.value <= lower_res.valid ? lower_res.value : '0;
    end

    // Same stage feeds the register file and the result ports
    assign upper_wr = upper_q;
    assign lower_wr = lower_q;
    assign wb_upper = upper_q;
    assign wb_lower = lower_q;

endmodule

`default_nettype wire

/* source/vliw_core.sv */
`timescale 1ns/1ps
`default_nettype none

module vliw_core (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [63:0]            bundle,
    input  logic                   bundle_valid,
    output logic                   busy,
    output pipe_pkg::lane_result_t wb_upper,
    output pipe_pkg::lane_result_t wb_lower
);
    import isa_pkg::*;
    import pipe_pkg::*;

    gpr_rd_t      upper_rd;
    gpr_rd_t      lower_rd;
    word_t        upper_a;
    word_t        upper_b;
    word_t        lower_a;
    word_t        lower_b;
    lane_op_t     upper_op;
    lane_op_t     lower_op;
    lane_result_t upper_res;
    lane_result_t lower_res;
    lane_result_t upper_wr;
    lane_result_t lower_wr;

    gpr_file u_gpr (
        .clk, .rstn, .upper_rd, .lower_rd,
        .upper_a, .upper_b, .lower_a, .lower_b,
        .upper_wr, .lower_wr
    );

    // Interlock against the decode and ALU stages
    hazard_unit u_hazard (
        .upper_rd, .lower_rd,
        .upper_kind (opcode_t'(bundle[63:58])),
        .lower_kind (opcode_t'(bundle[31:26])),
        .dec_upper  (upper_op),
        .dec_lower  (lower_op),
        .alu_upper  (upper_res),
        .alu_lower  (lower_res),
        .busy
    );

    bundle_decode u_decode (
        .clk, .rstn, .bundle, .bundle_valid, .busy,
        .upper_rd, .lower_rd,
        .upper_a, .upper_b, .lower_a, .lower_b,
        .upper_op, .lower_op
    );

    dual_alu u_alu (
        .clk, .rstn, .upper_op, .lower_op, .upper_res, .lower_res
    );

    writeback_unit u_wb (
        .clk, .rstn, .upper_res, .lower_res,
        .upper_wr, .lower_wr, .wb_upper, .wb_lower
    );

endmodule

`default_nettype wire

/* sim/vliw_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module vliw_core_assert (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [63:0]            bundle,
    input  logic                   bundle_valid,
    input  logic                   busy,
    input  pipe_pkg::lane_result_t wb_upper,
    input  pipe_pkg::lane_result_t wb_lower
);
    import isa_pkg::*;

    logic accept;
    logic liw_accept;

    assign accept     = bundle_valid && !busy;
    assign liw_accept = accept && (bundle[63:58] == OP_LIW);

    // Pipeline comes out of reset empty
    reset_idle: assert property (@(posedge clk)
        !rstn |=> !busy && !wb_upper.valid && !wb_lower.valid)
        else $error("pipeline not idle after reset");

    // Lower word of a liw is data and never writes back
    liw_lower_quiet: assert property (@(posedge clk) disable iff (!rstn)
        liw_accept |-> ##3 !wb_lower.valid)
        else $error("lower lane valid three edges after a liw bundle");

    // Every result traces back to a bundle taken three edges earlier
    result_source: assert property (@(posedge clk) disable iff (!rstn)
        (wb_upper.valid || wb_lower.valid) |-> $past(accept, 3))
        else $error("writeback result without a matching accepted bundle");

endmodule

bind vliw_core vliw_core_assert u_assert (
    .clk, .rstn, .bundle, .bundle_valid, .busy, .wb_upper, .wb_lower
);

`default_nettype wire

/* sim/vliw_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vliw_cfg.svh"

module vliw_core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int ACCEPT_LIMIT = 20;
    localparam int DRAIN_LIMIT  = 40;
    localparam int LATENCY      = 3;

    typedef struct packed {
        lane_result_t up;
        lane_result_t lo;
    } exp_pair_t;

    logic         clk;
    logic         rstn;
    logic [63:0]  bundle;
    logic         bundle_valid;
    logic         busy;
    lane_result_t wb_upper;
    lane_result_t wb_lower;

    word_t        gpr_model [`VLIW_NUM_GPR];
    exp_pair_t    expq [$];
    logic [31:0]  rng;
    int           since_accept;
    int           last_wait;
    int           checks;
    int           errors;
    int           tests_run;
    int           checks_mark;
    int           errors_mark;

    // Opcode mix for random bundles including nops and unsupported codes
    logic [5:0]   op_pool [16];

    vliw_core uut (
        .clk, .rstn, .bundle, .bundle_valid, .busy, .wb_upper, .wb_lower
    );

    always #50 clk = ~clk;

    always @(posedge clk)
        since_accept++;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] r;
        r = next_rand();
        return r[15:0];
    endfunction

    function automatic logic [31:0] enc_d(input logic [5:0] op, input reg_idx_t rt,
                                          input reg_idx_t ra, input logic [15:0] si);
        return {op, rt, ra, si};
    endfunction

    function automatic logic [31:0] enc_x(input logic [5:0] op, input reg_idx_t rt,
                                          input reg_idx_t ra, input reg_idx_t rb);
        return {op, rt, ra, rb, 11'd0};
    endfunction

    // Registers 0 to 7 only so that hazards come up often
    function automatic logic [31:0] random_slot();
        logic [31:0] r;
        logic [31:0] f;
        r = next_rand();
        f = next_rand();
        return {op_pool[r[3:0]], 2'b00, f[2:0], 2'b00, f[5:3], 2'b00, f[8:6], f[10:0]};
    endfunction

    // One slot per the ISA rules against the model as it was before the bundle
    function automatic lane_result_t lane_model(input logic [31:0] s, input logic [31:0] wide,
                                                input logic upper);
        lane_result_t r;
        word_t        a;
        word_t        b;
        word_t        imm;
        a       = gpr_model[s[20:16]];
        b       = gpr_model[s[15:11]];
        imm     = {{16{s[15]}}, s[15:0]};
        r.valid = 1'b1;
        r.rt    = s[25:21];
        r.value = '0;
        case (s[31:26])
            OP_ADDI:  r.value = a + imm;
            OP_SUBI:  r.value = a - imm;
            OP_ADD:   r.value = a + b;
            OP_SUB:   r.value = a - b;
            OP_SRAWI: r.value = $signed(a) >>> imm[4:0];
            OP_SLAWI: r.value = a << imm[4:0];
            OP_LI:    r.value = imm;
            OP_LIW: begin
                r.value = wide;
                r.valid = upper;
            end
            default:  r.valid = 1'b0;
        endcase
        if (!r.valid)
            r = '0;
        return r;
    endfunction

    function automatic void model_accept(input logic [63:0] b);
        exp_pair_t e;
        e.up = lane_model(b[63:32], b[31:0], 1'b1);
        if (b[63:58] == OP_LIW)
            e.lo = '0;
        else
            e.lo = lane_model(b[31:0], 32'd0, 1'b0);
        // Lower lane written last so it wins on a shared rt
        if (e.up.valid)
            gpr_model[e.up.rt] = e.up.value;
        if (e.lo.valid)
            gpr_model[e.lo.rt] = e.lo.value;
        if (e.up.valid || e.lo.valid)
            expq.push_back(e);
    endfunction

    function automatic logic lane_match(input lane_result_t got, input lane_result_t exp);
        if (got.valid !== exp.valid)
            return 1'b0;
        if (!exp.valid)
            return got.value === '0;
        return (got.rt === exp.rt) && (got.value === exp.value);
    endfunction

    task automatic check_lane(input string lane, input lane_result_t got,
                              input lane_result_t exp);
        assert (lane_match(got, exp)) else begin
            errors++;
            $display("FAILED at %0t: %s lane got %0b/%0d/%h, expected %0b/%0d/%h",
                     $time, lane, got.valid, got.rt, got.value,
                     exp.valid, exp.rt, exp.value);
        end
    endtask

    // Outputs settle between edges so compare on the falling edge
    always @(negedge clk) begin : check_results
        exp_pair_t e;
        if (rstn && (wb_upper.valid || wb_lower.valid)) begin
            assert (expq.size() != 0) else begin
                errors++;
                $display("Result appeared at %0t with no bundle pending", $time);
            end
            if (expq.size() != 0) begin
                e = expq.pop_front();
                checks++;
                check_lane("upper", wb_upper, e.up);
                check_lane("lower", wb_lower, e.lo);
            end
        end
    end

    task automatic report_timeout(input string why);
        errors++;
        $display("%s at time %0t", why, $time);
    endtask

    // Hold the bundle until an edge where busy is low
    task automatic issue(input logic [63:0] b);
        int   waited;
        logic taken;
        waited       = 0;
        taken        = 1'b0;
        bundle       = b;
        bundle_valid = 1'b1;
        while (!taken && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            taken = !busy;
            @(posedge clk);
            #1;
            waited++;
        end
        bundle_valid = 1'b0;
        last_wait    = waited;
        if (taken) begin
            model_accept(b);
            since_accept = 0;
        end else begin
            report_timeout("Bundle was never accepted");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((expq.size() != 0 || since_accept < LATENCY) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expq.size() != 0) begin
            report_timeout("Expected results never came out of the pipeline");
            expq.delete();
        end
    endtask

    task automatic close_test(input string name);
        drain();
        tests_run++;
        $display("Test %0d %s: %0d checks, %0d errors", tests_run, name,
                 checks - checks_mark, errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        bundle       = '0;
        bundle_valid = 1'b0;
        rng          = 32'h748def83;
        since_accept = LATENCY;
        last_wait    = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        checks_mark  = 0;
        errors_mark  = 0;
        gpr_model    = '{default: '0};
        op_pool      = '{OP_ADDI, OP_SUBI, OP_ADD, OP_SUB, OP_SRAWI, OP_SLAWI, OP_LI, OP_LI,
                         OP_ADDI, OP_ADD, OP_SUB, OP_LIW, 6'b111000, 6'b100100, OP_SUBI,
                         OP_SLAWI};
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        issue({enc_d(OP_LI, 5'd1, 5'd0, rand_imm()), enc_d(OP_LI, 5'd2, 5'd0, rand_imm())});
        issue({enc_d(OP_ADDI, 5'd3, 5'd1, rand_imm()), enc_d(OP_SUBI, 5'd4, 5'd2, rand_imm())});
        issue({enc_x(OP_ADD, 5'd5, 5'd1, 5'd2), enc_x(OP_SUB, 5'd6, 5'd1, 5'd2)});
        issue({enc_x(OP_SUB, 5'd7, 5'd3, 5'd4), enc_x(OP_ADD, 5'd8, 5'd4, 5'd3)});
        close_test("arithmetic");

        // Upper immediate bits above 4 must not change the shift amount
        issue({enc_d(OP_LI, 5'd9, 5'd0, 16'hFB2E), enc_d(OP_LI, 5'd10, 5'd0, 16'h05A5)});
        issue({enc_d(OP_SRAWI, 5'd11, 5'd9, 16'h0FE3), enc_d(OP_SLAWI, 5'd12, 5'd10, 16'h0007)});
        issue({enc_d(OP_SRAWI, 5'd13, 5'd10, 16'h001F), enc_d(OP_SLAWI, 5'd14, 5'd9, 16'h8014)});
        issue({enc_d(OP_SRAWI, 5'd15, 5'd9, rand_imm()), enc_d(OP_SLAWI, 5'd16, 5'd10, rand_imm())});
        close_test("shifts");

        issue({enc_d(OP_LIW, 5'd17, 5'd0, 16'd0), next_rand()});
        issue({enc_d(OP_LIW, 5'd18, 5'd0, 16'd0), enc_d(OP_ADDI, 5'd19, 5'd17, 16'd1)});
        issue({enc_d(OP_ADDI, 5'd20, 5'd17, 16'd0), enc_d(OP_ADDI, 5'd21, 5'd19, 16'd0)});
        close_test("liw");

        issue({enc_d(OP_ADDI, 5'd22, 5'd5, 16'd1), `VLIW_NOP_SLOT});
        issue({enc_x(OP_ADD, 5'd23, 5'd22, 5'd22), enc_d(OP_SUBI, 5'd24, 5'd22, 16'd3)});
        assert (last_wait > 1) else begin
            errors++;
            $display("Dependent bundle was not held by busy at time %0t", $time);
        end
        for (int i = 0; i < 48; i++)
            issue({random_slot(), random_slot()});
        close_test("interlock and random");

        // r28 is read back from the array well after both lanes wrote it
        issue({enc_d(OP_LI, 5'd28, 5'd0, 16'd5), enc_d(OP_LI, 5'd28, 5'd0, 16'd9)});
        issue({enc_d(OP_LI, 5'd25, 5'd0, 16'd11), enc_d(OP_LI, 5'd26, 5'd0, 16'd22)});
        issue({enc_d(OP_ADDI, 5'd25, 5'd26, 16'd1), enc_d(OP_ADDI, 5'd27, 5'd25, 16'd0)});
        issue({enc_d(OP_ADDI, 5'd29, 5'd28, 16'd0), enc_d(OP_ADDI, 5'd30, 5'd25, 16'd0)});
        close_test("same bundle");

        issue({`VLIW_NOP_SLOT, `VLIW_NOP_SLOT});
        issue({enc_d(6'b100000, 5'd1, 5'd2, 16'd1), enc_d(6'b110110, 5'd3, 5'd4, 16'd2)});
        issue({enc_d(6'b001111, 5'd5, 5'd6, 16'd3), enc_x(6'b011111, 5'd7, 5'd1, 5'd2)});
        // Read back the registers the unsupported opcodes named
        issue({enc_d(OP_ADDI, 5'd31, 5'd1, 16'd0), enc_d(OP_ADDI, 5'd30, 5'd3, 16'd0)});
        issue({enc_d(OP_ADDI, 5'd29, 5'd5, 16'd0), enc_d(OP_ADDI, 5'd28, 5'd7, 16'd0)});
        close_test("nop and unsupported");

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/gpr_file.sv
source/hazard_unit.sv
source/bundle_decode.sv
source/dual_alu.sv
source/writeback_unit.sv
source/vliw_core.sv
sim/vliw_core_assert.sv
sim/vliw_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the vliw_core regression with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module vliw_core_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vvliw_core_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
